//--- design/payload_trimmer.sv
`timescale 1ns/1ps

module payload_trimmer (
    input  logic                   clk,

    input  udp_rx_pkg::data_t      in_data,
    input  udp_rx_pkg::keep_t      in_keep,
    input  logic                   in_user,

    trim_ctrl_if.trimmer           ctrl,

    input  logic                   hold,
    output udp_rx_pkg::axis_word_t out_word
);

    udp_rx_pkg::byte_count_t remaining;
    udp_rx_pkg::byte_count_t udp_length;
    udp_rx_pkg::byte_count_t beat_bytes;
    udp_rx_pkg::keep_t       masked_keep;
    udp_rx_pkg::data_t       held_data;
    udp_rx_pkg::keep_t       held_keep;

    // length field sits in lanes 4 and 5, high byte first
    assign udp_length = {in_data[39:32], in_data[47:40]};

    assign beat_bytes  = udp_rx_pkg::byte_count_t'(udp_rx_pkg::keep_to_count(in_keep));
    assign masked_keep = in_keep & udp_rx_pkg::count_to_keep(remaining);

    assign ctrl.final_word = remaining <= udp_rx_pkg::byte_count_t'(udp_rx_pkg::DATA_BYTES);
    assign ctrl.short_end  = beat_bytes < remaining;

    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            remaining <= udp_length - udp_rx_pkg::byte_count_t'(udp_rx_pkg::DATA_BYTES);
        end else if (ctrl.advance) begin
            remaining <= remaining - udp_rx_pkg::byte_count_t'(udp_rx_pkg::DATA_BYTES);
        end
    end

    // last masked word, released later when the frame runs past its length
    always_ff @(posedge clk) begin
        if (ctrl.advance) begin
            held_data <= in_data;
            held_keep <= masked_keep;
        end
    end

    always_comb begin
        if (hold) begin
            out_word.data = held_data;
            out_word.keep = held_keep;
        end else begin
            out_word.data = in_data;
            out_word.keep = masked_keep;
        end
        // end of frame comes from the fsm
        out_word.last = 1'b0;
        // tuser of the beat being accepted, also for the held word
        out_word.user = in_user;
    end

endmodule

//--- design/stream_skid_buffer.sv
`timescale 1ns/1ps

module stream_skid_buffer #(
    parameter type T = logic [7:0]
) (
    input  logic clk,
    input  logic rst,

    input  logic in_valid,
    input  T     in_data,
    output logic in_ready,

    output logic out_valid,
    output T     out_data,
    input  logic out_ready
);

    logic out_valid_reg;
    logic temp_valid_reg;
    logic in_ready_reg;
    logic ready_early;
    T     out_reg;
    T     temp_reg;

    // stay ready unless the temp slot could fill up next cycle
    assign ready_early = out_ready || (!temp_valid_reg && (!out_valid_reg || !in_valid));

    assign in_ready  = in_ready_reg;
    assign out_valid = out_valid_reg;
    assign out_data  = out_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg  <= 1'b0;
            temp_valid_reg <= 1'b0;
            in_ready_reg   <= 1'b0;
        end else begin
            in_ready_reg <= ready_early;
            if (in_ready_reg) begin
                if (out_ready || !out_valid_reg) begin
                    out_valid_reg <= in_valid;
                end else begin
                    temp_valid_reg <= in_valid;
                end
            end else if (out_ready) begin
                // drain the temp slot into the output register
                out_valid_reg  <= temp_valid_reg;
                temp_valid_reg <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready_reg) begin
            if (out_ready || !out_valid_reg) begin
                out_reg <= in_data;
            end else begin
                temp_reg <= in_data;
            end
        end else if (out_ready) begin
            out_reg <= temp_reg;
        end
    end

endmodule

//--- design/trim_ctrl_if.sv
`timescale 1ns/1ps

interface trim_ctrl_if;

    // header beat accepted, start the byte count
    logic load;
    // payload beat accepted
    logic advance;
    // remaining count fits in this beat
    logic final_word;
    // input beat carries fewer bytes than still expected
    logic short_end;

    modport fsm (
        output load,
        output advance,
        input  final_word,
        input  short_end
    );

    modport trimmer (
        input  load,
        input  advance,
        output final_word,
        output short_end
    );

endinterface

//--- design/udp_rx_fsm.sv
`timescale 1ns/1ps

module udp_rx_fsm (
    input  logic        clk,
    input  logic        rst,

    input  logic        in_valid,
    input  logic        in_last,
    output logic        in_ready,

    input  logic        hdr_ready,
    input  logic        pay_ready,
    output logic        hdr_valid,
    output logic        pay_valid,
    output logic        pay_last,
    output logic        pay_user,
    output logic        hold,

    trim_ctrl_if.fsm    ctrl,

    output logic        error_header_early_termination,
    output logic        error_payload_early_termination
);

    typedef enum logic [1:0] {
        HEADER,
        PAYLOAD,
        HOLD
    } state_t;

    state_t state;
    state_t state_next;
    logic   accept;
    logic   hdr_early;
    logic   pay_early;

    // header beat goes to the header buffer, all later beats to the payload buffer
    assign in_ready = (state == HEADER) ? hdr_ready : pay_ready;
    assign accept   = in_valid && in_ready;
    assign hold     = state == HOLD;

    always_comb begin
        state_next   = state;
        hdr_valid    = 1'b0;
        pay_valid    = 1'b0;
        pay_last     = in_last;
        pay_user     = 1'b0;
        ctrl.load    = 1'b0;
        ctrl.advance = 1'b0;
        hdr_early    = 1'b0;
        pay_early    = 1'b0;

        case (state)
            HEADER: begin
                if (accept) begin
                    if (in_last) begin
                        // header only, no payload follows
                        hdr_early = 1'b1;
                    end else begin
                        hdr_valid  = 1'b1;
                        ctrl.load  = 1'b1;
                        state_next = PAYLOAD;
                    end
                end
            end
            PAYLOAD: begin
                if (accept) begin
                    ctrl.advance = 1'b1;
                    // final word waits in the trimmer until input tlast
                    pay_valid    = !ctrl.final_word || in_last;
                    if (in_last) begin
                        pay_early  = ctrl.short_end;
                        pay_user   = ctrl.short_end;
                        state_next = HEADER;
                    end else if (ctrl.final_word) begin
                        state_next = HOLD;
                    end
                end
            end
            HOLD: begin
                // discard trailing beats, release the held word on tlast
                if (accept && in_last) begin
                    pay_valid  = 1'b1;
                    state_next = HEADER;
                end
            end
            default: begin
                state_next = HEADER;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                           <= HEADER;
            error_header_early_termination  <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state                           <= state_next;
            error_header_early_termination  <= hdr_early;
            error_payload_early_termination <= pay_early;
        end
    end

endmodule

//--- design/udp_rx_pkg.sv
package udp_rx_pkg;

    localparam int DATA_BYTES = 8;

    typedef logic [DATA_BYTES*8-1:0] data_t;
    typedef logic [DATA_BYTES-1:0]   keep_t;
    typedef logic [15:0]             byte_count_t;

    // fields in network order once swapped out of the beat
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } axis_word_t;

    // keep is low-aligned and contiguous, so a plain bit count is enough
    function automatic logic [3:0] keep_to_count(keep_t keep);
        logic [3:0] count;
        count = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            count = count + 4'(keep[i]);
        end
        return count;
    endfunction

    function automatic keep_t count_to_keep(byte_count_t count);
        keep_t keep;
        for (int i = 0; i < DATA_BYTES; i++) begin
            keep[i] = count > byte_count_t'(i);
        end
        return keep;
    endfunction

endpackage

//--- design/udp_rx_top.sv
`timescale 1ns/1ps

module udp_rx_top (
    input  logic              clk,
    input  logic              rst,

    input  udp_rx_pkg::data_t s_payload_data,
    input  udp_rx_pkg::keep_t s_payload_keep,
    input  logic              s_payload_valid,
    input  logic              s_payload_last,
    input  logic              s_payload_user,
    output logic              s_payload_ready,

    output logic              m_hdr_valid,
    input  logic              m_hdr_ready,
    output logic [15:0]       m_src_port,
    output logic [15:0]       m_dst_port,
    output logic [15:0]       m_length,
    output logic [15:0]       m_checksum,

    output udp_rx_pkg::data_t m_payload_data,
    output udp_rx_pkg::keep_t m_payload_keep,
    output logic              m_payload_valid,
    output logic              m_payload_last,
    output logic              m_payload_user,
    input  logic              m_payload_ready,

    output logic              error_header_early_termination,
    output logic              error_payload_early_termination
);

    trim_ctrl_if ctrl ();

    logic                   hdr_in_valid;
    logic                   hdr_in_ready;
    logic                   pay_in_valid;
    logic                   pay_in_ready;
    logic                   pay_last;
    logic                   pay_user;
    logic                   hold;
    udp_rx_pkg::udp_hdr_t   hdr_in;
    udp_rx_pkg::udp_hdr_t   hdr_out;
    udp_rx_pkg::axis_word_t trim_word;
    udp_rx_pkg::axis_word_t pay_in;
    udp_rx_pkg::axis_word_t pay_out;

    // big-endian fields, most significant byte in the lower lane
    assign hdr_in.src_port = {s_payload_data[7:0],   s_payload_data[15:8]};
    assign hdr_in.dst_port = {s_payload_data[23:16], s_payload_data[31:24]};
    assign hdr_in.length   = {s_payload_data[39:32], s_payload_data[47:40]};
    assign hdr_in.checksum = {s_payload_data[55:48], s_payload_data[63:56]};

    // last follows input tlast, a short frame forces tuser
    assign pay_in.data = trim_word.data;
    assign pay_in.keep = trim_word.keep;
    assign pay_in.last = pay_last;
    assign pay_in.user = trim_word.user || pay_user;

    udp_rx_fsm u_fsm (
        .clk                             (clk),
        .rst                             (rst),
        .in_valid                        (s_payload_valid),
        .in_last                         (s_payload_last),
        .in_ready                        (s_payload_ready),
        .hdr_ready                       (hdr_in_ready),
        .pay_ready                       (pay_in_ready),
        .hdr_valid                       (hdr_in_valid),
        .pay_valid                       (pay_in_valid),
        .pay_last                        (pay_last),
        .pay_user                        (pay_user),
        .hold                            (hold),
        .ctrl                            (ctrl.fsm),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination)
    );

    payload_trimmer u_trimmer (
        .clk      (clk),
        .in_data  (s_payload_data),
        .in_keep  (s_payload_keep),
        .in_user  (s_payload_user),
        .ctrl     (ctrl.trimmer),
        .hold     (hold),
        .out_word (trim_word)
    );

    stream_skid_buffer #(
        .T (udp_rx_pkg::udp_hdr_t)
    ) u_hdr_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (hdr_in_valid),
        .in_data   (hdr_in),
        .in_ready  (hdr_in_ready),
        .out_valid (m_hdr_valid),
        .out_data  (hdr_out),
        .out_ready (m_hdr_ready)
    );

    stream_skid_buffer #(
        .T (udp_rx_pkg::axis_word_t)
    ) u_payload_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (pay_in_valid),
        .in_data   (pay_in),
        .in_ready  (pay_in_ready),
        .out_valid (m_payload_valid),
        .out_data  (pay_out),
        .out_ready (m_payload_ready)
    );

    assign m_src_port = hdr_out.src_port;
    assign m_dst_port = hdr_out.dst_port;
    assign m_length   = hdr_out.length;
    assign m_checksum = hdr_out.checksum;

    assign m_payload_data = pay_out.data;
    assign m_payload_keep = pay_out.keep;
    assign m_payload_last = pay_out.last;
    assign m_payload_user = pay_out.user;

endmodule

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, then decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module udp_rx_tb -f verilog.f -o udp_rx_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/udp_rx_sim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

//--- testbench/udp_rx_assertions.sv
`timescale 1ns/1ps

module udp_rx_assertions (
    input logic        clk,
    input logic        rst,
    input logic        s_payload_valid,
    input logic        s_payload_ready,
    input logic        s_payload_last,
    input logic        m_hdr_valid,
    input logic        m_hdr_ready,
    input logic [15:0] m_src_port,
    input logic [15:0] m_dst_port,
    input logic [15:0] m_length,
    input logic [15:0] m_checksum,
    input logic [63:0] m_payload_data,
    input logic [7:0]  m_payload_keep,
    input logic        m_payload_valid,
    input logic        m_payload_last,
    input logic        m_payload_user,
    input logic        m_payload_ready,
    input logic        error_header_early_termination,
    input logic        error_payload_early_termination
);

    logic last_accepted;

    assign last_accepted = s_payload_valid && s_payload_ready && s_payload_last;

    // stalled header holds valid and fields
    assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=>
            m_hdr_valid && $stable({m_src_port, m_dst_port, m_length, m_checksum}))
    else $error("header output changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        m_payload_valid && !m_payload_ready |=>
            m_payload_valid &&
            $stable({m_payload_data, m_payload_keep, m_payload_last, m_payload_user}))
    else $error("payload output changed while stalled");

    // back-to-back one-beat frames give one pulse each
    assert property (@(posedge clk) disable iff (rst)
        error_header_early_termination |=>
            !error_header_early_termination || $past(last_accepted))
    else $error("header error pulse longer than one cycle");

    assert property (@(posedge clk) disable iff (rst)
        error_payload_early_termination |=> !error_payload_early_termination)
    else $error("payload error pulse longer than one cycle");

    // low-aligned keep has no gap, so keep + 1 shares no bit with keep
    assert property (@(posedge clk) disable iff (rst)
        m_payload_valid |-> ((m_payload_keep + 8'd1) & m_payload_keep) == 8'd0)
    else $error("payload keep not contiguous");

endmodule

bind udp_rx_top udp_rx_assertions u_assertions (
    .clk                             (clk),
    .rst                             (rst),
    .s_payload_valid                 (s_payload_valid),
    .s_payload_ready                 (s_payload_ready),
    .s_payload_last                  (s_payload_last),
    .m_hdr_valid                     (m_hdr_valid),
    .m_hdr_ready                     (m_hdr_ready),
    .m_src_port                      (m_src_port),
    .m_dst_port                      (m_dst_port),
    .m_length                        (m_length),
    .m_checksum                      (m_checksum),
    .m_payload_data                  (m_payload_data),
    .m_payload_keep                  (m_payload_keep),
    .m_payload_valid                 (m_payload_valid),
    .m_payload_last                  (m_payload_last),
    .m_payload_user                  (m_payload_user),
    .m_payload_ready                 (m_payload_ready),
    .error_header_early_termination  (error_header_early_termination),
    .error_payload_early_termination (error_payload_early_termination)
);

//--- testbench/udp_rx_tb.sv
`timescale 1ns/1ps

module udp_rx_tb;

    localparam int FRAMES    = 60;
    localparam int MAX_BEATS = 12;
    localparam int TIMEOUT   = 500;

    logic clk;
    logic rst;

    udp_rx_pkg::data_t s_payload_data;
    udp_rx_pkg::keep_t s_payload_keep;
    logic              s_payload_valid;
    logic              s_payload_last;
    logic              s_payload_user;
    logic              s_payload_ready;

    logic              m_hdr_valid;
    logic              m_hdr_ready;
    logic [15:0]       m_src_port;
    logic [15:0]       m_dst_port;
    logic [15:0]       m_length;
    logic [15:0]       m_checksum;

    udp_rx_pkg::data_t m_payload_data;
    udp_rx_pkg::keep_t m_payload_keep;
    logic              m_payload_valid;
    logic              m_payload_last;
    logic              m_payload_user;
    logic              m_payload_ready;

    logic              error_header_early_termination;
    logic              error_payload_early_termination;

    integer seed = 89987;

    // model output, in arrival order
    udp_rx_pkg::udp_hdr_t   exp_hdr[$];
    udp_rx_pkg::axis_word_t exp_word[$];
    logic [1:0]             exp_err[$];

    // beats of the frame being sent
    udp_rx_pkg::data_t fr_data[MAX_BEATS];
    udp_rx_pkg::keep_t fr_keep[MAX_BEATS];
    logic              fr_user[MAX_BEATS];
    int                fr_count[MAX_BEATS];

    udp_rx_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR: %s", msg);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input logic [79:0] exp,
                                   input logic [79:0] got);
        $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
        stop_run();
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // output ready redrawn on every falling edge
    task automatic next_cycle();
        @(negedge clk);
        m_hdr_ready     = rand_range(0, 1) == 1;
        m_payload_ready = rand_range(0, 3) != 0;
    endtask

    task automatic make_frame(output int beats, output int len);
        logic [31:0] hi;
        logic [31:0] lo;
        int          i;
        int          b;
        beats = rand_range(1, MAX_BEATS);
        len   = rand_range(9, 80);
        for (i = 0; i < beats; i++) begin
            hi = $random(seed);
            lo = $random(seed);
            fr_data[i]  = {hi, lo};
            fr_user[i]  = rand_range(0, 3) == 0;
            fr_count[i] = (i == beats - 1) ? rand_range(1, 8) : 8;
            for (b = 0; b < 8; b++) begin
                fr_keep[i][b] = b < fr_count[i];
            end
        end
        // length field, high byte in lane 4
        fr_data[0][39:32] = len[15:8];
        fr_data[0][47:40] = len[7:0];
    endtask

    task automatic predict_frame(input int beats, input int len);
        udp_rx_pkg::udp_hdr_t   hdr;
        udp_rx_pkg::axis_word_t word;
        int                     remaining;
        int                     i;
        int                     b;
        logic                   last;
        logic                   short_end;
        if (beats == 1) begin
            exp_err.push_back(2'b10);
        end else begin
            // each field has its high byte in the lower lane
            hdr.src_port = {fr_data[0][7:0], fr_data[0][15:8]};
            hdr.dst_port = {fr_data[0][23:16], fr_data[0][31:24]};
            hdr.length   = {fr_data[0][39:32], fr_data[0][47:40]};
            hdr.checksum = {fr_data[0][55:48], fr_data[0][63:56]};
            exp_hdr.push_back(hdr);
            remaining = len - 8;
            for (i = 1; i < beats; i++) begin
                last      = i == beats - 1;
                short_end = last && fr_count[i] < remaining;
                word.data = fr_data[i];
                for (b = 0; b < 8; b++) begin
                    word.keep[b] = fr_keep[i][b] && b < remaining;
                end
                if (remaining > 8 || last) begin
                    word.last = last;
                    word.user = fr_user[i] || short_end;
                    exp_word.push_back(word);
                    if (short_end) begin
                        exp_err.push_back(2'b01);
                    end
                end else begin
                    // length reached early, word waits for input tlast
                    word.last = 1'b1;
                    word.user = fr_user[beats - 1];
                    exp_word.push_back(word);
                    break;
                end
                remaining = remaining - 8;
            end
        end
    endtask

    task automatic send_beat(input int i, input logic last);
        int waited;
        repeat (rand_range(0, 2)) next_cycle();
        s_payload_data  = fr_data[i];
        s_payload_keep  = fr_keep[i];
        s_payload_user  = fr_user[i];
        s_payload_last  = last;
        s_payload_valid = 1'b1;
        waited = 0;
        while (!s_payload_ready) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                report_failure("input ready stayed low, beat not accepted");
            end
        end
        next_cycle();
        s_payload_valid = 1'b0;
    endtask

    task automatic check_hdr(input udp_rx_pkg::udp_hdr_t got);
        udp_rx_pkg::udp_hdr_t exp;
        if (exp_hdr.size() == 0) begin
            report_failure("header output while no header was expected");
        end else begin
            exp = exp_hdr.pop_front();
            if (got.src_port !== exp.src_port) begin
                report_mismatch("m_src_port", 80'(exp.src_port), 80'(got.src_port));
            end else if (got.dst_port !== exp.dst_port) begin
                report_mismatch("m_dst_port", 80'(exp.dst_port), 80'(got.dst_port));
            end else if (got.length !== exp.length) begin
                report_mismatch("m_length", 80'(exp.length), 80'(got.length));
            end else if (got.checksum !== exp.checksum) begin
                report_mismatch("m_checksum", 80'(exp.checksum), 80'(got.checksum));
            end
        end
    endtask

    task automatic check_word(input udp_rx_pkg::axis_word_t got);
        udp_rx_pkg::axis_word_t exp;
        logic                   data_ok;
        int                     b;
        if (exp_word.size() == 0) begin
            report_failure("payload output while no word was expected");
        end else begin
            exp = exp_word.pop_front();
            data_ok = 1'b1;
            // bytes outside keep are not compared
            for (b = 0; b < 8; b++) begin
                if (exp.keep[b] && got.data[8*b +: 8] !== exp.data[8*b +: 8]) begin
                    data_ok = 1'b0;
                end
            end
            if (!data_ok) begin
                report_mismatch("m_payload_data", 80'(exp.data), 80'(got.data));
            end else if (got.keep !== exp.keep) begin
                report_mismatch("m_payload_keep", 80'(exp.keep), 80'(got.keep));
            end else if (got.last !== exp.last) begin
                report_mismatch("m_payload_last", 80'(exp.last), 80'(got.last));
            end else if (got.user !== exp.user) begin
                report_mismatch("m_payload_user", 80'(exp.user), 80'(got.user));
            end
        end
    endtask

    task automatic check_error(input logic hdr_err, input logic pay_err);
        logic [1:0] exp;
        if (exp_err.size() == 0) begin
            report_failure("error pulse while no error was expected");
        end else begin
            exp = exp_err.pop_front();
            if (hdr_err !== exp[1]) begin
                report_mismatch("error_header_early_termination", 80'(exp[1]), 80'(hdr_err));
            end else if (pay_err !== exp[0]) begin
                report_mismatch("error_payload_early_termination", 80'(exp[0]), 80'(pay_err));
            end
        end
    endtask

    // values sampled before the edge updates them
    always @(posedge clk) begin
        if (!rst) begin
            if (m_hdr_valid && m_hdr_ready) begin
                check_hdr({m_src_port, m_dst_port, m_length, m_checksum});
            end
            if (m_payload_valid && m_payload_ready) begin
                check_word({m_payload_data, m_payload_keep, m_payload_last, m_payload_user});
            end
            if (error_header_early_termination || error_payload_early_termination) begin
                check_error(error_header_early_termination, error_payload_early_termination);
            end
        end
    end

    initial begin
        int beats;
        int len;
        int f;
        int i;
        int waited;
        rst             = 1'b1;
        s_payload_data  = '0;
        s_payload_keep  = '0;
        s_payload_valid = 1'b0;
        s_payload_last  = 1'b0;
        s_payload_user  = 1'b0;
        m_hdr_ready     = 1'b0;
        m_payload_ready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (m_hdr_valid || m_payload_valid || error_header_early_termination ||
            error_payload_early_termination) begin
            report_failure("outputs not idle after reset");
        end
        for (f = 0; f < FRAMES; f++) begin
            make_frame(beats, len);
            predict_frame(beats, len);
            for (i = 0; i < beats; i++) begin
                send_beat(i, i == beats - 1);
            end
        end
        waited = 0;
        while (exp_hdr.size() + exp_word.size() + exp_err.size() != 0) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                report_failure("expected outputs never arrived");
            end
        end
        // quiet period, any extra output trips the monitor
        repeat (20) next_cycle();
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verilog.f
design/udp_rx_pkg.sv
design/trim_ctrl_if.sv
design/stream_skid_buffer.sv
design/payload_trimmer.sv
design/udp_rx_fsm.sv
design/udp_rx_top.sv
testbench/udp_rx_assertions.sv
testbench/udp_rx_tb.sv
